// ==== source/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

  // widths that carry a meaning across the core
  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [6:0]  opcode_t;
  typedef logic [2:0]  funct3_t;
  typedef logic [3:0]  byte_en_t;
  typedef logic [3:0]  alu_op_t;
  typedef logic [1:0]  wb_sel_t;

  // major opcodes
  localparam opcode_t OP_LOAD   = 7'b0000011;
  localparam opcode_t OP_STORE  = 7'b0100011;
  localparam opcode_t OP_BRANCH = 7'b1100011;
  localparam opcode_t OP_JALR   = 7'b1100111;
  localparam opcode_t OP_JAL    = 7'b1101111;
  localparam opcode_t OP_IMM    = 7'b0010011;
  localparam opcode_t OP_REG    = 7'b0110011;
  localparam opcode_t OP_SYSTEM = 7'b1110011;
  localparam opcode_t OP_AUIPC  = 7'b0010111;
  localparam opcode_t OP_LUI    = 7'b0110111;

  // funct3 for arithmetic, branches and memory access size
  localparam funct3_t F3_ADD  = 3'b000;
  localparam funct3_t F3_SLL  = 3'b001;
  localparam funct3_t F3_SLT  = 3'b010;
  localparam funct3_t F3_SLTU = 3'b011;
  localparam funct3_t F3_XOR  = 3'b100;
  localparam funct3_t F3_SR   = 3'b101;
  localparam funct3_t F3_OR   = 3'b110;
  localparam funct3_t F3_AND  = 3'b111;

  localparam funct3_t F3_BEQ  = 3'b000;
  localparam funct3_t F3_BNE  = 3'b001;
  localparam funct3_t F3_BLT  = 3'b100;
  localparam funct3_t F3_BGE  = 3'b101;
  localparam funct3_t F3_BLTU = 3'b110;
  localparam funct3_t F3_BGEU = 3'b111;

  localparam funct3_t F3_B  = 3'b000;
  localparam funct3_t F3_H  = 3'b001;
  localparam funct3_t F3_W  = 3'b010;
  localparam funct3_t F3_BU = 3'b100;
  localparam funct3_t F3_HU = 3'b101;

  // funct7 picks sub and sra
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;

  localparam alu_op_t ALU_ADD    = 4'd0;
  localparam alu_op_t ALU_SUB    = 4'd1;
  localparam alu_op_t ALU_SLL    = 4'd2;
  localparam alu_op_t ALU_SLT    = 4'd3;
  localparam alu_op_t ALU_SLTU   = 4'd4;
  localparam alu_op_t ALU_XOR    = 4'd5;
  localparam alu_op_t ALU_SRL    = 4'd6;
  localparam alu_op_t ALU_SRA    = 4'd7;
  localparam alu_op_t ALU_OR     = 4'd8;
  localparam alu_op_t ALU_AND    = 4'd9;
  localparam alu_op_t ALU_PASS_B = 4'd10;

  localparam wb_sel_t WB_ALU  = 2'd0;
  localparam wb_sel_t WB_LOAD = 2'd1;
  localparam wb_sel_t WB_LINK = 2'd2;

endpackage

`default_nettype wire

// ==== source/decode_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface decode_if;
  import rv_pkg::*;

  reg_idx_t rs1;
  reg_idx_t rs2;
  reg_idx_t rd;
  word_t    imm;
  alu_op_t  alu_op;
  logic     alu_a_pc;
  logic     alu_b_imm;
  logic     reg_write;
  wb_sel_t  wb_sel;
  logic     is_branch;
  logic     is_jal;
  logic     is_jalr;
  logic     is_load;
  logic     is_store;
  funct3_t  funct3;
  logic     halt;

  modport decoder (
    output rs1, rs2, rd, imm, alu_op, alu_a_pc, alu_b_imm, reg_write, wb_sel,
    output is_branch, is_jal, is_jalr, is_load, is_store, funct3, halt
  );

  modport execute (
    input rs1, rs2, rd, imm, alu_op, alu_a_pc, alu_b_imm, reg_write, wb_sel,
    input is_branch, is_jal, is_jalr, funct3, halt
  );

  // memory side only needs the access kind and size
  modport mem (
    input is_load, is_store, funct3
  );

endinterface

`default_nettype wire

// ==== source/insn_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module insn_decoder (
  input rv_pkg::word_t insn,
  decode_if.decoder    dec
);
  import rv_pkg::*;

  opcode_t    opcode;
  funct3_t    funct3;
  logic [6:0] funct7;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_j;
  word_t      imm_u;
  logic       is_reg_op;
  logic       f7_base_ok;
  alu_op_t    arith_op;
  logic       arith_ok;

  assign opcode = insn[6:0];
  assign funct3 = insn[14:12];
  assign funct7 = insn[31:25];

  // sign-extended immediates where b and j keep bit 0 at zero
  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
  assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
  assign imm_u = {insn[31:12], 12'b0};

  assign is_reg_op  = (opcode == OP_REG);
  assign f7_base_ok = !is_reg_op || (funct7 == F7_BASE);

  // alu operation shared by register-register and register-immediate forms
  always_comb begin
    arith_op = ALU_ADD;
    arith_ok = f7_base_ok;
    case (funct3)
      F3_ADD: begin
        arith_op = (is_reg_op && funct7 == F7_ALT) ? ALU_SUB : ALU_ADD;
        arith_ok = f7_base_ok || (funct7 == F7_ALT);
      end
      F3_SLL: begin
        arith_op = ALU_SLL;
        // slli also needs a clean upper field
        arith_ok = (funct7 == F7_BASE);
      end
      F3_SLT:  arith_op = ALU_SLT;
      F3_SLTU: arith_op = ALU_SLTU;
      F3_XOR:  arith_op = ALU_XOR;
      F3_SR: begin
        arith_op = (funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
        arith_ok = (funct7 == F7_BASE) || (funct7 == F7_ALT);
      end
      F3_OR:   arith_op = ALU_OR;
      default: arith_op = ALU_AND;
    endcase
  end

  always_comb begin
    dec.rs1       = insn[19:15];
    dec.rs2       = insn[24:20];
    dec.rd        = insn[11:7];
    dec.funct3    = funct3;
    dec.imm       = imm_i;
    dec.alu_op    = ALU_ADD;
    dec.alu_a_pc  = 1'b0;
    dec.alu_b_imm = 1'b0;
    dec.reg_write = 1'b0;
    dec.wb_sel    = WB_ALU;
    dec.is_branch = 1'b0;
    dec.is_jal    = 1'b0;
    dec.is_jalr   = 1'b0;
    dec.is_load   = 1'b0;
    dec.is_store  = 1'b0;
    dec.halt      = 1'b0;
    // anything not matched below falls through as a no-op
    case (opcode)
      OP_LUI: begin
        dec.imm       = imm_u;
        dec.alu_op    = ALU_PASS_B;
        dec.alu_b_imm = 1'b1;
        dec.reg_write = 1'b1;
      end
      OP_AUIPC: begin
        dec.imm       = imm_u;
        dec.alu_a_pc  = 1'b1;
        dec.alu_b_imm = 1'b1;
        dec.reg_write = 1'b1;
      end
      OP_JAL: begin
        dec.imm       = imm_j;
        dec.is_jal    = 1'b1;
        dec.reg_write = 1'b1;
        dec.wb_sel    = WB_LINK;
      end
      OP_JALR: begin
        if (funct3 == 3'b000) begin
          dec.alu_b_imm = 1'b1;
          dec.is_jalr   = 1'b1;
          dec.reg_write = 1'b1;
          dec.wb_sel    = WB_LINK;
        end
      end
      OP_BRANCH: begin
        dec.imm       = imm_b;
        // funct3 010 and 011 are not branches
        dec.is_branch = (funct3 != 3'b010) && (funct3 != 3'b011);
      end
      OP_LOAD: begin
        if (funct3 == F3_B || funct3 == F3_H || funct3 == F3_W ||
            funct3 == F3_BU || funct3 == F3_HU) begin
          dec.alu_b_imm = 1'b1;
          dec.is_load   = 1'b1;
          dec.reg_write = 1'b1;
          dec.wb_sel    = WB_LOAD;
        end
      end
      OP_STORE: begin
        dec.imm       = imm_s;
        dec.alu_b_imm = 1'b1;
        dec.is_store  = (funct3 == F3_B) || (funct3 == F3_H) || (funct3 == F3_W);
      end
      OP_IMM: begin
        dec.alu_op    = arith_op;
        dec.alu_b_imm = 1'b1;
        dec.reg_write = arith_ok;
      end
      OP_REG: begin
        dec.alu_op    = arith_op;
        dec.reg_write = arith_ok;
      end
      OP_SYSTEM: begin
        // only ecall stops the core
        dec.halt = (insn[31:7] == '0);
      end
      default: begin
        dec.reg_write = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== source/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file (
  input  logic             clk,
  input  logic             rst,
  input  rv_pkg::reg_idx_t rs1_idx,
  input  rv_pkg::reg_idx_t rs2_idx,
  input  rv_pkg::reg_idx_t rd_idx,
  input  logic             we,
  input  rv_pkg::word_t    rd_data,
  output rv_pkg::word_t    rs1_data,
  output rv_pkg::word_t    rs2_data
);
  import rv_pkg::*;

  localparam int NUM_REGS = 32;

  word_t regs [NUM_REGS];

  // two asynchronous read ports
  assign rs1_data = regs[rs1_idx];
  assign rs2_data = regs[rs2_idx];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd_idx != '0) begin
      // x0 stays zero since it is never written
      regs[rd_idx] <= rd_data;
    end
  end

endmodule

`default_nettype wire

// ==== source/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu (
  input  rv_pkg::alu_op_t op,
  input  rv_pkg::word_t   a,
  input  rv_pkg::word_t   b,
  output rv_pkg::word_t   result
);
  import rv_pkg::*;

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  // shifts only look at the low five bits
  assign shamt       = b[4:0];
  assign lt_signed   = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  always_comb begin
    case (op)
      ALU_ADD:    result = a + b;
      ALU_SUB:    result = a - b;
      ALU_SLL:    result = a << shamt;
      ALU_SLT:    result = {31'b0, lt_signed};
      ALU_SLTU:   result = {31'b0, lt_unsigned};
      ALU_XOR:    result = a ^ b;
      ALU_SRL:    result = a >> shamt;
      ALU_SRA:    result = word_t'($signed(a) >>> shamt);
      ALU_OR:     result = a | b;
      ALU_AND:    result = a & b;
      ALU_PASS_B: result = b;
      default:    result = a + b;
    endcase
  end

endmodule

`default_nettype wire

// ==== source/execute_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_unit #(
  parameter rv_pkg::word_t RESET_PC = '0
) (
  input  logic          clk,
  input  logic          rst,
  decode_if.execute     dec,
  output rv_pkg::word_t pc,
  output rv_pkg::word_t eff_addr,
  output rv_pkg::word_t rs2_data,
  input  rv_pkg::word_t load_value
);
  import rv_pkg::*;

  word_t rs1_data;
  word_t alu_a;
  word_t alu_b;
  word_t alu_result;
  word_t pc_plus4;
  word_t jump_target;
  word_t next_pc;
  word_t wb_data;
  logic  branch_cond;
  logic  rf_we;

  // no register write while halted
  assign rf_we = dec.reg_write && !dec.halt;

  reg_file i_reg_file (
    .clk      (clk),
    .rst      (rst),
    .rs1_idx  (dec.rs1),
    .rs2_idx  (dec.rs2),
    .rd_idx   (dec.rd),
    .we       (rf_we),
    .rd_data  (wb_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  assign alu_a = dec.alu_a_pc ? pc : rs1_data;
  assign alu_b = dec.alu_b_imm ? dec.imm : rs2_data;

  alu i_alu (
    .op     (dec.alu_op),
    .a      (alu_a),
    .b      (alu_b),
    .result (alu_result)
  );

  // loads, stores and jalr all use the alu sum rs1 + imm
  assign eff_addr    = alu_result;
  assign pc_plus4    = pc + 32'd4;
  assign jump_target = pc + dec.imm;

  always_comb begin
    case (dec.funct3)
      F3_BEQ:  branch_cond = (rs1_data == rs2_data);
      F3_BNE:  branch_cond = (rs1_data != rs2_data);
      F3_BLT:  branch_cond = ($signed(rs1_data) < $signed(rs2_data));
      F3_BGE:  branch_cond = ($signed(rs1_data) >= $signed(rs2_data));
      F3_BLTU: branch_cond = (rs1_data < rs2_data);
      F3_BGEU: branch_cond = (rs1_data >= rs2_data);
      default: branch_cond = 1'b0;
    endcase
  end

  always_comb begin
    if (dec.halt) begin
      next_pc = pc;
    end else if (dec.is_jalr) begin
      next_pc = {alu_result[31:1], 1'b0};
    end else if (dec.is_jal || (dec.is_branch && branch_cond)) begin
      next_pc = jump_target;
    end else begin
      next_pc = pc_plus4;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= RESET_PC;
    end else begin
      pc <= next_pc;
    end
  end

  always_comb begin
    case (dec.wb_sel)
      WB_LOAD: wb_data = load_value;
      WB_LINK: wb_data = pc_plus4;
      default: wb_data = alu_result;
    endcase
  end

endmodule

`default_nettype wire

// ==== source/mem_access.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_access (
  decode_if.mem            dec,
  input  rv_pkg::word_t    eff_addr,
  input  rv_pkg::word_t    rs2_data,
  input  rv_pkg::word_t    dmem_load_data,
  output rv_pkg::word_t    load_value,
  output rv_pkg::word_t    dmem_addr,
  output rv_pkg::word_t    dmem_store_data,
  output rv_pkg::byte_en_t dmem_byte_en
);
  import rv_pkg::*;

  logic [1:0] lane;
  word_t      load_shifted;

  assign lane      = eff_addr[1:0];
  assign dmem_addr = {eff_addr[31:2], 2'b00};

  // move the low bytes of rs2 up to the addressed lane
  assign dmem_store_data = rs2_data << {lane, 3'b000};

  always_comb begin
    dmem_byte_en = '0;
    if (dec.is_store) begin
      case (dec.funct3)
        F3_B:    dmem_byte_en = 4'b0001 << lane;
        F3_H:    dmem_byte_en = lane[1] ? 4'b1100 : 4'b0011;
        F3_W:    dmem_byte_en = 4'b1111;
        default: dmem_byte_en = '0;
      endcase
    end
  end

  // addressed byte or halfword ends up in the low bits
  assign load_shifted = dmem_load_data >> {lane, 3'b000};

  always_comb begin
    load_value = '0;
    if (dec.is_load) begin
      case (dec.funct3)
        F3_B:    load_value = {{24{load_shifted[7]}}, load_shifted[7:0]};
        F3_H:    load_value = {{16{load_shifted[15]}}, load_shifted[15:0]};
        F3_BU:   load_value = {24'b0, load_shifted[7:0]};
        F3_HU:   load_value = {16'b0, load_shifted[15:0]};
        F3_W:    load_value = dmem_load_data;
        default: load_value = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== source/rv32_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv32_core #(
  parameter rv_pkg::word_t RESET_PC = '0
) (
  input  logic             clk,
  input  logic             rst,
  output rv_pkg::word_t    imem_addr,
  input  rv_pkg::word_t    imem_data,
  output rv_pkg::word_t    dmem_addr,
  input  rv_pkg::word_t    dmem_load_data,
  output rv_pkg::word_t    dmem_store_data,
  output rv_pkg::byte_en_t dmem_byte_en,
  output logic             halt
);
  import rv_pkg::*;

  word_t    pc;
  word_t    eff_addr;
  word_t    rs2_data;
  word_t    load_value;
  byte_en_t byte_en;

  decode_if dec_bus ();

  insn_decoder i_insn_decoder (
    .insn (imem_data),
    .dec  (dec_bus.decoder)
  );

  execute_unit #(
    .RESET_PC (RESET_PC)
  ) i_execute_unit (
    .clk        (clk),
    .rst        (rst),
    .dec        (dec_bus.execute),
    .pc         (pc),
    .eff_addr   (eff_addr),
    .rs2_data   (rs2_data),
    .load_value (load_value)
  );

  mem_access i_mem_access (
    .dec             (dec_bus.mem),
    .eff_addr        (eff_addr),
    .rs2_data        (rs2_data),
    .dmem_load_data  (dmem_load_data),
    .load_value      (load_value),
    .dmem_addr       (dmem_addr),
    .dmem_store_data (dmem_store_data),
    .dmem_byte_en    (byte_en)
  );

  assign imem_addr = pc;

  // imem may return garbage during reset so stores and halt stay quiet
  assign dmem_byte_en = rst ? '0 : byte_en;
  assign halt         = dec_bus.halt && !rst;

endmodule

`default_nettype wire

// ==== verification/tb_program.svh ====
task automatic build_program();
  word_t base_pc;
  word_t junk;
  junk = i_type(12'd99, 5'd0, F3_ADD, 5'd5, OP_IMM);
  // spare words are nops that carry their own word index
  for (int i = 0; i < 256; i++) begin
    prog[i] = 32'h0000_0013 | (word_t'(i) << 20);
  end
  for (int i = 0; i < 64; i++) begin
    dmem[i] = 32'h5A5A_0000 ^ (i * 32'h0001_0203);
  end
  // load source words where every byte of word 0 has its top bit set
  dmem[0] = 32'hF0E1_D2C3;
  dmem[1] = 32'h8765_4321;

  // every executed instruction below adds one row to the expected trace
  // operands
  run_insn(i_type(12'hFFB, 5'd0, F3_ADD, 5'd1, OP_IMM));
  run_insn(i_type(12'd7, 5'd0, F3_ADD, 5'd2, OP_IMM));
  run_insn(u_type(20'h80000, 5'd3, OP_LUI));
  base_pc = word_t'(prog_len) << 2;
  run_insn(u_type(20'h00001, 5'd4, OP_AUIPC));
  store_word(5'd3, 32'h8000_0000);
  store_word(5'd4, base_pc + 32'h1000);

  // register-register with x1 = -5 and x2 = 7
  run_insn(r_type(F7_BASE, 5'd2, 5'd1, F3_ADD, 5'd5));
  store_word(5'd5, 32'h0000_0002);
  run_insn(r_type(F7_ALT, 5'd2, 5'd1, F3_ADD, 5'd5));
  store_word(5'd5, 32'hFFFF_FFF4);
  run_insn(r_type(F7_BASE, 5'd2, 5'd1, F3_SLL, 5'd5));
  store_word(5'd5, 32'hFFFF_FD80);
  run_insn(r_type(F7_BASE, 5'd2, 5'd1, F3_SLT, 5'd5));
  store_word(5'd5, 32'h0000_0001);
  run_insn(r_type(F7_BASE, 5'd2, 5'd1, F3_SLTU, 5'd5));
  store_word(5'd5, 32'h0000_0000);
  run_insn(r_type(F7_BASE, 5'd2, 5'd1, F3_XOR, 5'd5));
  store_word(5'd5, 32'hFFFF_FFFC);
  run_insn(r_type(F7_BASE, 5'd2, 5'd1, F3_SR, 5'd5));
  store_word(5'd5, 32'h01FF_FFFF);
  run_insn(r_type(F7_ALT, 5'd2, 5'd1, F3_SR, 5'd5));
  store_word(5'd5, 32'hFFFF_FFFF);
  run_insn(r_type(F7_BASE, 5'd2, 5'd1, F3_OR, 5'd5));
  store_word(5'd5, 32'hFFFF_FFFF);
  run_insn(r_type(F7_BASE, 5'd2, 5'd1, F3_AND, 5'd5));
  store_word(5'd5, 32'h0000_0003);

  // register-immediate
  run_insn(i_type(12'd100, 5'd1, F3_ADD, 5'd5, OP_IMM));
  store_word(5'd5, 32'h0000_005F);
  run_insn(i_type(12'hFFC, 5'd1, F3_SLT, 5'd5, OP_IMM));
  store_word(5'd5, 32'h0000_0001);
  run_insn(i_type(12'hFFC, 5'd1, F3_SLTU, 5'd5, OP_IMM));
  store_word(5'd5, 32'h0000_0001);
  run_insn(i_type(12'hFFF, 5'd2, F3_SLT, 5'd5, OP_IMM));
  store_word(5'd5, 32'h0000_0000);
  run_insn(i_type(12'hFFF, 5'd2, F3_SLTU, 5'd5, OP_IMM));
  store_word(5'd5, 32'h0000_0001);
  run_insn(i_type(12'hFFF, 5'd1, F3_XOR, 5'd5, OP_IMM));
  store_word(5'd5, 32'h0000_0004);
  run_insn(i_type(12'h070, 5'd2, F3_OR, 5'd5, OP_IMM));
  store_word(5'd5, 32'h0000_0077);
  run_insn(i_type(12'h0F0, 5'd1, F3_AND, 5'd5, OP_IMM));
  store_word(5'd5, 32'h0000_00F0);
  run_insn(i_type(12'd28, 5'd2, F3_SLL, 5'd5, OP_IMM));
  store_word(5'd5, 32'h7000_0000);
  run_insn(i_type(12'h004, 5'd3, F3_SR, 5'd5, OP_IMM));
  store_word(5'd5, 32'h0800_0000);
  run_insn(i_type(12'h404, 5'd3, F3_SR, 5'd5, OP_IMM));
  store_word(5'd5, 32'hF800_0000);

  // x0 ignores writes and x31 was never written
  run_insn(i_type(12'd55, 5'd0, F3_ADD, 5'd0, OP_IMM));
  store_word(5'd0, 32'h0);
  store_word(5'd31, 32'h0);

  // each branch kind taken and not taken
  branch_taken(F3_BEQ, 5'd2, 5'd2, junk);
  run_insn(b_type(13'd8, 5'd2, 5'd1, F3_BEQ));
  branch_taken(F3_BNE, 5'd1, 5'd2, junk);
  run_insn(b_type(13'd8, 5'd2, 5'd2, F3_BNE));
  branch_taken(F3_BLT, 5'd1, 5'd2, junk);
  run_insn(b_type(13'd8, 5'd1, 5'd2, F3_BLT));
  branch_taken(F3_BGE, 5'd2, 5'd1, junk);
  run_insn(b_type(13'd8, 5'd2, 5'd1, F3_BGE));
  branch_taken(F3_BLTU, 5'd2, 5'd1, junk);
  run_insn(b_type(13'd8, 5'd2, 5'd1, F3_BLTU));
  branch_taken(F3_BGEU, 5'd1, 5'd2, junk);
  run_insn(b_type(13'd8, 5'd1, 5'd2, F3_BGEU));

  base_pc = word_t'(prog_len) << 2;
  run_insn(j_type(21'd8, 5'd7));
  skip_insn(junk);
  store_word(5'd7, base_pc + 32'd4);

  // odd jalr target loses bit 0
  base_pc = word_t'(prog_len) << 2;
  run_insn(u_type(20'h00000, 5'd8, OP_AUIPC));
  run_insn(i_type(12'd13, 5'd8, 3'b000, 5'd9, OP_JALR));
  skip_insn(junk);
  store_word(5'd9, base_pc + 32'd8);

  // store lanes with x10 = 0x11223344
  run_insn(u_type(20'h11223, 5'd10, OP_LUI));
  run_insn(i_type(12'h344, 5'd10, F3_ADD, 5'd10, OP_IMM));
  record(s_type(12'h080, 5'd10, 5'd0, F3_B), 32'h80, 32'h0000_0044, 4'b0001, 1'b0);
  record(s_type(12'h081, 5'd10, 5'd0, F3_B), 32'h80, 32'h0000_4400, 4'b0010, 1'b0);
  record(s_type(12'h082, 5'd10, 5'd0, F3_B), 32'h80, 32'h0044_0000, 4'b0100, 1'b0);
  record(s_type(12'h083, 5'd10, 5'd0, F3_B), 32'h80, 32'h4400_0000, 4'b1000, 1'b0);
  record(s_type(12'h080, 5'd10, 5'd0, F3_H), 32'h80, 32'h0000_3344, 4'b0011, 1'b0);
  record(s_type(12'h082, 5'd10, 5'd0, F3_H), 32'h80, 32'h3344_0000, 4'b1100, 1'b0);

  // loads that are each stored back
  run_insn(i_type(12'd1, 5'd0, F3_B, 5'd11, OP_LOAD));
  store_word(5'd11, 32'hFFFF_FFD2);
  run_insn(i_type(12'd3, 5'd0, F3_BU, 5'd11, OP_LOAD));
  store_word(5'd11, 32'h0000_00F0);
  run_insn(i_type(12'd2, 5'd0, F3_H, 5'd11, OP_LOAD));
  store_word(5'd11, 32'hFFFF_F0E1);
  run_insn(i_type(12'd0, 5'd0, F3_HU, 5'd11, OP_LOAD));
  store_word(5'd11, 32'h0000_D2C3);
  run_insn(i_type(12'd4, 5'd0, F3_W, 5'd11, OP_LOAD));
  store_word(5'd11, 32'h8765_4321);
  run_insn(i_type(12'd4, 5'd0, F3_B, 5'd11, OP_LOAD));
  store_word(5'd11, 32'h0000_0021);

  // ecall and then the core sits still
  record(32'h0000_0073, 32'h0, 32'h0, 4'b0000, 1'b1);
  hold_halt(5);
endtask

// ==== verification/tb_rv32_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_rv32_core;
  import rv_pkg::*;

  localparam int RESET_CYCLES = 10;
  localparam int MAX_ROWS     = 256;

  logic     clk;
  logic     rst;
  word_t    imem_addr;
  word_t    imem_data;
  word_t    dmem_addr;
  word_t    dmem_load_data;
  word_t    dmem_store_data;
  byte_en_t dmem_byte_en;
  logic     halt;

  word_t    prog [256];
  word_t    dmem [64];
  int       prog_len = 0;
  int       trace_len = 0;
  word_t    exp_pc [MAX_ROWS];
  word_t    exp_addr [MAX_ROWS];
  word_t    exp_data [MAX_ROWS];
  byte_en_t exp_be [MAX_ROWS];
  logic     exp_halt [MAX_ROWS];
  int       cycle_count = 0;
  int       timeout_limit = 1000;

  function automatic word_t r_type(input logic [6:0] f7, input reg_idx_t rs2,
                                   input reg_idx_t rs1, input funct3_t f3, input reg_idx_t rd);
    return {f7, rs2, rs1, f3, rd, OP_REG};
  endfunction

  function automatic word_t i_type(input logic [11:0] imm, input reg_idx_t rs1,
                                   input funct3_t f3, input reg_idx_t rd, input opcode_t op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic word_t s_type(input logic [11:0] imm, input reg_idx_t rs2,
                                   input reg_idx_t rs1, input funct3_t f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE};
  endfunction

  function automatic word_t b_type(input logic [12:0] imm, input reg_idx_t rs2,
                                   input reg_idx_t rs1, input funct3_t f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
  endfunction

  function automatic word_t u_type(input logic [19:0] imm, input reg_idx_t rd,
                                   input opcode_t op);
    return {imm, rd, op};
  endfunction

  function automatic word_t j_type(input logic [20:0] imm, input reg_idx_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
  endfunction

  // one 0xff byte per enabled lane
  function automatic word_t lane_mask(input byte_en_t be);
    return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
  endfunction

  task automatic record(input word_t insn, input word_t addr, input word_t data,
                        input byte_en_t be, input logic hlt);
    exp_pc[trace_len]   = word_t'(prog_len) << 2;
    exp_addr[trace_len] = addr;
    exp_data[trace_len] = data;
    exp_be[trace_len]   = be;
    exp_halt[trace_len] = hlt;
    prog[prog_len]      = insn;
    prog_len++;
    trace_len++;
  endtask

  task automatic run_insn(input word_t insn);
    record(insn, 32'h0, 32'h0, 4'b0000, 1'b0);
  endtask

  // placed in memory but jumped over
  task automatic skip_insn(input word_t insn);
    prog[prog_len] = insn;
    prog_len++;
  endtask

  task automatic store_word(input reg_idx_t rs, input word_t value);
    record(s_type(12'h080, rs, 5'd0, F3_W), 32'h80, value, 4'b1111, 1'b0);
  endtask

  task automatic branch_taken(input funct3_t f3, input reg_idx_t rs1, input reg_idx_t rs2,
                              input word_t junk);
    run_insn(b_type(13'd8, rs2, rs1, f3));
    skip_insn(junk);
  endtask

  task automatic hold_halt(input int n);
    for (int i = 0; i < n; i++) begin
      exp_pc[trace_len]   = word_t'(prog_len - 1) << 2;
      exp_addr[trace_len] = 32'h0;
      exp_data[trace_len] = 32'h0;
      exp_be[trace_len]   = 4'b0000;
      exp_halt[trace_len] = 1'b1;
      trace_len++;
    end
  endtask

  `include "tb_program.svh"

  task automatic check_word(input string what, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("[ERROR] %0t ns: %s got %h, expected %h", $time, what, got, exp);
      $display("Finished with errors");
      $fatal(1);
    end
  endtask

  task automatic check_byte_en(input byte_en_t got, input byte_en_t exp);
    if (got !== exp) begin
      $display("[ERROR] %0t ns: dmem_byte_en got %b, expected %b", $time, got, exp);
      $display("Finished with errors");
      $fatal(1);
    end
  endtask

  task automatic check_halt(input logic got, input logic exp);
    if (got !== exp) begin
      $display("[ERROR] %0t ns: halt got %b, expected %b", $time, got, exp);
      $display("Finished with errors");
      $fatal(1);
    end
  endtask

  rv32_core i_dut (
    .clk             (clk),
    .rst             (rst),
    .imem_addr       (imem_addr),
    .imem_data       (imem_data),
    .dmem_addr       (dmem_addr),
    .dmem_load_data  (dmem_load_data),
    .dmem_store_data (dmem_store_data),
    .dmem_byte_en    (dmem_byte_en),
    .halt            (halt)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // both memories answer in the same cycle
  assign imem_data      = prog[imem_addr[9:2]];
  assign dmem_load_data = dmem[dmem_addr[7:2]];

  always @(posedge clk) begin : dmem_write
    for (int k = 0; k < 4; k++) begin
      if (dmem_byte_en[k]) begin
        dmem[dmem_addr[7:2]][8*k +: 8] <= dmem_store_data[8*k +: 8];
      end
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_limit) begin
      $display("Timeout: the trace did not finish within %0d cycles", timeout_limit);
      $display("Finished with errors");
      $fatal(1);
    end
  end

  initial begin
    rst = 1'b1;
    build_program();
    timeout_limit = RESET_CYCLES + trace_len + 20;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 rst = 1'b0;
    // sample each row 1 ns before the edge that retires it
    #2;
    for (int row = 0; row < trace_len; row++) begin
      check_word("imem_addr", imem_addr, exp_pc[row]);
      check_byte_en(dmem_byte_en, exp_be[row]);
      if (exp_be[row] != 4'b0000) begin
        check_word("dmem_addr", dmem_addr, exp_addr[row]);
        check_word("dmem_store_data", dmem_store_data & lane_mask(exp_be[row]),
                   exp_data[row]);
      end
      check_halt(halt, exp_halt[row]);
      @(posedge clk);
      #3;
    end
    $display("Finished with no errors");
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+verification
source/rv_pkg.sv
source/decode_if.sv
source/insn_decoder.sv
source/reg_file.sv
source/alu.sv
source/execute_unit.sv
source/mem_access.sv
source/rv32_core.sv
verification/tb_rv32_core.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_rv32_core
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
SIM_BIN   ?= sim_$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/$(SIM_BIN): $(FILELIST)
	$(VERILATOR) --binary --timing --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(SIM_BIN)

sim: $(BUILD_DIR)/$(SIM_BIN)
	./$(BUILD_DIR)/$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)
